/* char_q_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Read side of the keyboard queue
interface char_q_if;
  import mmap_pkg::*;

  logic      pop;    // One entry per cycle
  key_code_t head;   // Oldest code, valid when not empty
  logic      empty;
  logic      full;

  modport controller (
    output pop,
    input  head, empty, full
  );

  modport queue (
    input  pop,
    output head, empty, full
  );

endinterface

`default_nettype wire

/* char_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module char_queue (
  input  wire                 clk,
  input  wire                 rst_n,
  // Decoded key events
  input  wire                 key_valid_i,  // One-cycle pulse
  input  wire                 key_make_i,   // Low for break events
  input  mmap_pkg::key_code_t key_code_i,
  char_q_if.queue             q,
  output logic                drop_o        // Valid key lost to full queue
);
  import mmap_pkg::*;

  key_code_t              entries [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr;
  logic [QUEUE_PTR_W-1:0] rd_ptr;
  logic [QUEUE_CNT_W-1:0] count;
  logic                   accept;
  logic                   push;
  logic                   pop;

  ////////////////////////////////////////
  // Filtering
  ////////////////////////////////////////
  assign accept = key_valid_i & key_make_i & (key_code_i != '0);  // Makes only
  assign push   = accept & ~q.full;
  assign drop_o = accept & q.full;
  assign pop    = q.pop & ~q.empty;

  ////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= key_code_i;
    end
  end

  // Head is combinational
  assign q.head  = entries[rd_ptr];
  assign q.empty = (count == '0);
  assign q.full  = (count == QUEUE_CNT_W'(QUEUE_DEPTH));

endmodule

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module data_ram (
  input  wire     clk,
  ram_port_if.ram ram
);
  import mmap_pkg::*;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////
  word_t mem [DMEM_WORDS];  // No reset, contents undefined at start

  // Per-lane write, be bit 3 is bits 31:24
  always_ff @(posedge clk) begin
    for (int b = 0; b < LANES; b++) begin
      if (ram.we[b]) begin
        mem[ram.index][b*8 +: 8] <= ram.wdata[b*8 +: 8];
      end
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////
  // Registered read, holds between strobes
  always_ff @(posedge clk) begin
    if (ram.re) begin
      ram.rdata <= mem[ram.index];
    end
  end

endmodule

`default_nettype wire

/* flist.f */
mmap_pkg.sv
ram_port_if.sv
char_q_if.sv
mmap_ctrl.sv
lane_align.sv
data_ram.sv
char_queue.sv
mmap_top.sv
tb_mmap.sv

/* lane_align.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_align (
  input  wire                    clk,
  input  wire                    rst_n,
  input  mmap_pkg::addr_t        addr_i,
  input  mmap_pkg::access_size_t size_i,
  input  mmap_pkg::word_t        wdata_i,
  input  wire                    wr_i,
  input  wire                    rd_i,
  ram_port_if.aligner            ram,
  output mmap_pkg::word_t        load_o
);
  import mmap_pkg::*;

  logic [1:0]   offset;
  logic [1:0]   offset_q;    // Load offset, aligned with RAM data
  access_size_t size_q;
  byte_en_t     store_be;
  word_t        store_data;
  word_t        byte_shifted;

  assign offset = addr_i[1:0];

  ////////////////////////////////////////
  // Store side
  ////////////////////////////////////////
  // Offset 0 is the MSB lane
  always_comb begin
    case (size_i)
      SIZE_BYTE: begin
        store_data = wdata_i << {~offset, 3'b000};  // 0->24, 3->0
        store_be   = byte_en_t'(4'b1000 >> offset);
      end
      SIZE_HALF: begin
        if (!offset[1]) begin
          store_data = {wdata_i[15:0], 16'h0000};  // Lanes 0-1
          store_be   = 4'b1100;
        end else begin
          store_data = {16'h0000, wdata_i[15:0]};  // Lanes 2-3
          store_be   = 4'b0011;
        end
      end
      default: begin
        store_data = wdata_i;  // Whole word
        store_be   = 4'b1111;
      end
    endcase
  end

  assign ram.we    = wr_i ? store_be : '0;
  assign ram.re    = rd_i;
  assign ram.index = addr_i[RAM_INDEX_W+1:2];
  assign ram.wdata = store_data;

  ////////////////////////////////////////
  // Load side
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      offset_q <= 2'b00;
      size_q   <= SIZE_WORD;
    end else if (rd_i) begin
      offset_q <= offset;
      size_q   <= size_i;
    end
  end

  assign byte_shifted = ram.rdata >> {~offset_q, 3'b000};

  always_comb begin
    case (size_q)
      SIZE_WORD: load_o = ram.rdata;
      SIZE_BYTE: load_o = {24'h000000, byte_shifted[7:0]};  // Zero-extended
      SIZE_HALF: load_o = offset_q[1] ? {16'h0000, ram.rdata[15:0]}
                                      : {16'h0000, ram.rdata[31:16]};
      default:   load_o = '0;  // Unsupported size
    endcase
  end

  // Half accesses come aligned from the processor
  assert property (@(posedge clk) disable iff (!rst_n)
                   ((wr_i || rd_i) && size_i == SIZE_HALF) |-> !addr_i[0])
    else $error("misaligned half-word access");

  assert property (@(posedge clk) disable iff (!rst_n)
                   (wr_i || rd_i) |-> (size_i inside {SIZE_WORD, SIZE_BYTE, SIZE_HALF}))
    else $error("unsupported access size");

endmodule

`default_nettype wire

/* mmap_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module mmap_ctrl (
  input  wire                clk,
  input  wire                rst_n,
  // Processor bus
  input  mmap_pkg::addr_t    bus_addr_i,
  input  wire                bus_we_i,
  input  wire                bus_re_i,
  input  mmap_pkg::word_t    bus_wdata_i,
  // RAM path through lane aligner
  input  mmap_pkg::word_t    ram_load_i,
  output logic               ram_wr_o,
  output logic               ram_rd_o,
  // Keyboard queue
  char_q_if.controller       q,
  input  wire                drop_i,
  // Video mode
  input  wire                mode_force_i,
  output logic               video_mode_o,
  // Read response
  output mmap_pkg::word_t    bus_rdata_o,
  output logic               bus_rvalid_o
);
  import mmap_pkg::*;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////
  logic  is_ram;
  logic  is_key_char;
  logic  is_key_status;
  logic  is_video_mode;
  logic  status_rd;
  logic  video_mode_q;
  logic  drop_flag_q;
  logic  resp_ram_q;   // RAM answers this response
  logic  rvalid_q;
  word_t status_word;
  word_t reg_word;
  word_t reg_word_q;   // Captured register/queue value

  assign is_ram        = (bus_addr_i < DMEM_LIMIT);
  assign is_key_char   = (bus_addr_i == ADDR_KEY_CHAR);
  assign is_key_status = (bus_addr_i == ADDR_KEY_STATUS);
  assign is_video_mode = (bus_addr_i == ADDR_VIDEO_MODE);

  assign ram_wr_o  = bus_we_i & is_ram;
  assign ram_rd_o  = bus_re_i & is_ram;
  assign q.pop     = bus_re_i & is_key_char & ~q.empty;  // Only a real read pops
  assign status_rd = bus_re_i & is_key_status;

  ////////////////////////////////////////
  // Video mode and drop flag
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      video_mode_q <= 1'b0;
    end else if (bus_we_i && is_video_mode) begin
      video_mode_q <= bus_wdata_i[0];
    end
  end

  assign video_mode_o = video_mode_q | mode_force_i;  // Force wins

  // New drop beats the clear from a status read in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_flag_q <= 1'b0;
    end else if (drop_i) begin
      drop_flag_q <= 1'b1;
    end else if (status_rd) begin
      drop_flag_q <= 1'b0;
    end
  end

  always_comb begin
    status_word                       = '0;
    status_word[KEY_STATUS_NOT_EMPTY] = ~q.empty;
    status_word[KEY_STATUS_FULL]      = q.full;
    status_word[KEY_STATUS_DROP]      = drop_flag_q;
  end

  // Register space read value, unmapped reads zero
  always_comb begin
    reg_word = '0;
    if (is_key_char) begin
      reg_word = q.empty ? '0 : word_t'(q.head);  // Empty queue reads zero
    end else if (is_key_status) begin
      reg_word = status_word;
    end else if (is_video_mode) begin
      reg_word = word_t'(video_mode_q);
    end
  end

  ////////////////////////////////////////
  // Response stage
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_ram_q <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= bus_re_i;
      if (bus_re_i) begin
        resp_ram_q <= is_ram;  // Held between reads
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus_re_i) begin
      reg_word_q <= reg_word;
    end
  end

  // Both sources hold between reads, so rdata holds too
  assign bus_rdata_o  = resp_ram_q ? ram_load_i : reg_word_q;
  assign bus_rvalid_o = rvalid_q;

  // One access per cycle on the bus
  assert property (@(posedge clk) disable iff (!rst_n) !(bus_re_i && bus_we_i))
    else $error("bus read and write strobes high together");

  // Popped entries are real key codes
  assert property (@(posedge clk) disable iff (!rst_n) q.pop |-> (q.head != '0))
    else $error("pop took a zero code from the key queue");

endmodule

`default_nettype wire

/* mmap_pkg.sv */
`default_nettype none

package mmap_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int KEY_W       = 8;
  localparam int LANES       = 4;  // Byte lanes per word
  localparam int DMEM_WORDS  = 1024;  // 4 KB data memory
  localparam int RAM_INDEX_W = $clog2(DMEM_WORDS);
  localparam int QUEUE_DEPTH = 8;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = QUEUE_PTR_W + 1;  // Count reaches DEPTH

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [DATA_W-1:0]      word_t;
  typedef logic [KEY_W-1:0]       key_code_t;
  typedef logic [LANES-1:0]       byte_en_t;  // Bit 3 is lane 0, MSB
  typedef logic [RAM_INDEX_W-1:0] ram_index_t;

  // Access size, value 3 unsupported
  typedef enum logic [1:0] {
    SIZE_WORD = 2'd0,
    SIZE_BYTE = 2'd1,
    SIZE_HALF = 2'd2
  } access_size_t;

  ////////////////////////////////////////
  // Address map
  ////////////////////////////////////////
  localparam addr_t DMEM_LIMIT      = 32'h0000_1000;  // RAM below this
  localparam addr_t ADDR_KEY_CHAR   = 32'h0001_0000;  // Read pops queue
  localparam addr_t ADDR_KEY_STATUS = 32'h0001_0004;
  localparam addr_t ADDR_VIDEO_MODE = 32'h0001_0008;  // R/W, bit 0 only

  // Keyboard status word bits, rest read zero
  localparam int KEY_STATUS_NOT_EMPTY = 0;
  localparam int KEY_STATUS_FULL      = 1;
  localparam int KEY_STATUS_DROP      = 2;  // Sticky until status read

endpackage

`default_nettype wire

/* mmap_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mmap_top (
  input  wire                    clk,
  input  wire                    rst_n,
  // Processor bus
  input  mmap_pkg::addr_t        bus_addr_i,
  input  wire                    bus_we_i,
  input  wire                    bus_re_i,
  input  mmap_pkg::access_size_t bus_size_i,
  input  mmap_pkg::word_t        bus_wdata_i,
  output mmap_pkg::word_t        bus_rdata_o,
  output logic                   bus_rvalid_o,
  // Key events
  input  wire                    key_valid_i,
  input  wire                    key_make_i,
  input  mmap_pkg::key_code_t    key_code_i,
  // Video mode
  input  wire                    mode_force_i,
  output logic                   video_mode_o
);
  import mmap_pkg::*;

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////
  word_t ram_load;  // Aligned load data
  logic  ram_wr;
  logic  ram_rd;
  logic  key_drop;

  ram_port_if ram_bus ();
  char_q_if   key_q ();

  mmap_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_addr_i   (bus_addr_i),
    .bus_we_i     (bus_we_i),
    .bus_re_i     (bus_re_i),
    .bus_wdata_i  (bus_wdata_i),
    .ram_load_i   (ram_load),
    .ram_wr_o     (ram_wr),
    .ram_rd_o     (ram_rd),
    .q            (key_q.controller),
    .drop_i       (key_drop),
    .mode_force_i (mode_force_i),
    .video_mode_o (video_mode_o),
    .bus_rdata_o  (bus_rdata_o),
    .bus_rvalid_o (bus_rvalid_o)
  );

  lane_align u_align (
    .clk     (clk),
    .rst_n   (rst_n),
    .addr_i  (bus_addr_i),
    .size_i  (bus_size_i),
    .wdata_i (bus_wdata_i),
    .wr_i    (ram_wr),  // Already gated by decode
    .rd_i    (ram_rd),
    .ram     (ram_bus.aligner),
    .load_o  (ram_load)
  );

  data_ram u_ram (
    .clk (clk),
    .ram (ram_bus.ram)
  );

  char_queue u_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .key_valid_i (key_valid_i),
    .key_make_i  (key_make_i),
    .key_code_i  (key_code_i),
    .q           (key_q.queue),
    .drop_o      (key_drop)
  );

endmodule

`default_nettype wire

/* ram_port_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Word port between lane aligner and data RAM
interface ram_port_if;
  import mmap_pkg::*;

  byte_en_t   we;     // Per-lane write enables
  logic       re;     // Read strobe, data next cycle
  ram_index_t index;  // Word index
  word_t      wdata;  // Already lane-shifted
  word_t      rdata;  // Registered read data

  modport aligner (
    output we, re, index, wdata,
    input  rdata
  );

  modport ram (
    input  we, re, index, wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the memory-map testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_mmap -f flist.f -o sim_mmap \
  && ./obj_dir/sim_mmap > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "^Finished with no errors$" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

/* tb_mmap.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mmap;
  import mmap_pkg::*;

  localparam int TIMEOUT_CYCLES = 20;  // Max wait for pending reads

  logic         clk = 1'b0;
  logic         rst_n;
  addr_t        bus_addr_i;
  logic         bus_we_i;
  logic         bus_re_i;
  access_size_t bus_size_i;
  word_t        bus_wdata_i;
  word_t        bus_rdata_o;
  logic         bus_rvalid_o;
  logic         key_valid_i;
  logic         key_make_i;
  key_code_t    key_code_i;
  logic         mode_force_i;
  logic         video_mode_o;

  // Reference model state
  word_t       mem_model [DMEM_WORDS];
  key_code_t   key_model [$];
  logic        drop_model;
  logic        mode_model;
  word_t       exp_q [$];      // Expected read data, oldest first
  int unsigned due_q [$];      // Cycle in which each response is due
  int unsigned cycle_cnt = 0;
  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] rng;

  mmap_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_addr_i   (bus_addr_i),
    .bus_we_i     (bus_we_i),
    .bus_re_i     (bus_re_i),
    .bus_size_i   (bus_size_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_rdata_o  (bus_rdata_o),
    .bus_rvalid_o (bus_rvalid_o),
    .key_valid_i  (key_valid_i),
    .key_make_i   (key_make_i),
    .key_code_i   (key_code_i),
    .mode_force_i (mode_force_i),
    .video_mode_o (video_mode_o)
  );

  always #20 clk = ~clk;  // 40 ns period

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  // Responses sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    if (due_q.size() != 0 && due_q[0] == cycle_cnt) begin
      compare_bit("bus_rvalid_o", bus_rvalid_o, 1'b1);
      if (bus_rvalid_o) begin
        compare_word("bus_rdata_o", bus_rdata_o, exp_q[0]);
      end
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
    end else if (bus_rvalid_o) begin
      $display("Error at %0t: bus_rvalid_o high with no read pending", $time);
      errors++;
    end
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Big-endian lanes, offset 0 is bits 31:24
  function automatic word_t merge_store(input word_t old_w, input word_t data,
                                        input access_size_t size, input logic [1:0] off);
    word_t w;
    int    hi;
    w  = old_w;
    hi = 31 - 8 * int'(off);
    case (size)
      SIZE_BYTE: w[hi -: 8] = data[7:0];
      SIZE_HALF: begin
        if (off[1]) w[15:0] = data[15:0];  // Lanes 2 and 3
        else        w[31:16] = data[15:0];
      end
      default:   w = data;
    endcase
    return w;
  endfunction

  function automatic word_t extract_load(input word_t w, input access_size_t size,
                                         input logic [1:0] off);
    int hi;
    hi = 31 - 8 * int'(off);
    case (size)
      SIZE_BYTE: return {24'h000000, w[hi -: 8]};
      SIZE_HALF: return off[1] ? {16'h0000, w[15:0]} : {16'h0000, w[31:16]};
      default:   return w;
    endcase
  endfunction

  function automatic word_t ram_expect(input addr_t addr, input access_size_t size);
    return extract_load(mem_model[addr[RAM_INDEX_W+1:2]], size, addr[1:0]);
  endfunction

  function automatic word_t key_char_expect();
    if (key_model.size() == 0) return '0;  // Empty queue reads zero
    return word_t'(key_model.pop_front());
  endfunction

  function automatic word_t status_expect();
    word_t s;
    s = '0;
    s[KEY_STATUS_NOT_EMPTY] = (key_model.size() != 0);
    s[KEY_STATUS_FULL]      = (key_model.size() == QUEUE_DEPTH);
    s[KEY_STATUS_DROP]      = drop_model;
    drop_model = 1'b0;  // Cleared by this read
    return s;
  endfunction

  ////////////////////////////////////////
  // Bus and key drivers
  ////////////////////////////////////////
  task automatic bus_write(input addr_t addr, input access_size_t size, input word_t data);
    ram_index_t idx;
    idx = addr[RAM_INDEX_W+1:2];
    @(posedge clk);
    bus_we_i    <= 1'b1;
    bus_re_i    <= 1'b0;
    bus_addr_i  <= addr;
    bus_size_i  <= size;
    bus_wdata_i <= data;
    if (addr < DMEM_LIMIT) begin
      mem_model[idx] = merge_store(mem_model[idx], data, size, addr[1:0]);
    end else if (addr == ADDR_VIDEO_MODE) begin
      mode_model = data[0];
    end
    // Other addresses are dropped
  endtask

  task automatic bus_read(input addr_t addr, input access_size_t size, input word_t exp);
    @(posedge clk);
    bus_we_i   <= 1'b0;
    bus_re_i   <= 1'b1;
    bus_addr_i <= addr;
    bus_size_i <= size;
    exp_q.push_back(exp);
    due_q.push_back(cycle_cnt + 2);  // Sampled one full cycle later
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    bus_we_i <= 1'b0;
    bus_re_i <= 1'b0;
  endtask

  task automatic key_event(input logic make, input key_code_t code);
    @(posedge clk);
    bus_we_i    <= 1'b0;
    bus_re_i    <= 1'b0;
    key_valid_i <= 1'b1;
    key_make_i  <= make;
    key_code_i  <= code;
    if (make && code != '0) begin
      if (key_model.size() < QUEUE_DEPTH) key_model.push_back(code);
      else drop_model = 1'b1;  // Lost to a full queue
    end
    @(posedge clk);
    key_valid_i <= 1'b0;  // Single-cycle pulse
  endtask

  task automatic set_force(input logic value);
    @(posedge clk);
    bus_we_i     <= 1'b0;
    bus_re_i     <= 1'b0;
    mode_force_i <= value;
  endtask

  task automatic check_mode(input logic exp);
    @(negedge clk);
    compare_bit("video_mode_o", video_mode_o, exp);
  endtask

  task automatic drain_reads();
    int waited;
    waited = 0;
    idle_cycle();
    while (due_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    if (due_q.size() != 0) begin
      $display("Error at %0t: read responses still missing after %0d cycles",
               $time, TIMEOUT_CYCLES);
      errors++;
      exp_q.delete();
      due_q.delete();
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, errors - err_before);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic word_read_write();
    addr_t addrs [8];
    int    err_before;
    err_before = errors;
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      addrs[i] = addr_t'({rng[RAM_INDEX_W-1:0], 2'b00});
      rng = xorshift(rng);
      bus_write(addrs[i], SIZE_WORD, rng);
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(addrs[i], SIZE_WORD, ram_expect(addrs[i], SIZE_WORD));  // Back to back
    end
    rng = xorshift(rng);
    bus_write(addrs[3], SIZE_WORD, rng);
    bus_read(addrs[3], SIZE_WORD, ram_expect(addrs[3], SIZE_WORD));  // Read after write
    drain_reads();
    end_test("word_read_write", err_before);
  endtask

  task automatic lane_access();
    addr_t base;
    int    err_before;
    err_before = errors;
    rng  = xorshift(rng);
    base = addr_t'({rng[RAM_INDEX_W-1:0], 2'b00});
    bus_write(base, SIZE_WORD, 32'h1122_3344);
    for (int k = 0; k < 4; k++) begin
      rng = xorshift(rng);  // Upper bits must be ignored
      bus_write(base + addr_t'(k), SIZE_BYTE, rng);
      bus_read(base, SIZE_WORD, ram_expect(base, SIZE_WORD));
      bus_read(base + addr_t'(k), SIZE_BYTE, ram_expect(base + addr_t'(k), SIZE_BYTE));
    end
    for (int k = 0; k < 4; k += 2) begin
      rng = xorshift(rng);
      bus_write(base + addr_t'(k), SIZE_HALF, rng);
      bus_read(base, SIZE_WORD, ram_expect(base, SIZE_WORD));
      bus_read(base + addr_t'(k), SIZE_HALF, ram_expect(base + addr_t'(k), SIZE_HALF));
    end
    for (int k = 0; k < 4; k++) begin
      bus_read(base + addr_t'(k), SIZE_BYTE, ram_expect(base + addr_t'(k), SIZE_BYTE));
    end
    drain_reads();
    end_test("lane_access", err_before);
  endtask

  task automatic key_filtering();
    int err_before;
    err_before = errors;
    key_event(1'b1, 8'h41);
    key_event(1'b0, 8'h41);  // Break
    key_event(1'b1, 8'h00);  // Zero code
    key_event(1'b1, 8'h42);
    key_event(1'b0, 8'h42);
    key_event(1'b0, 8'h00);
    key_event(1'b1, 8'h5a);
    for (int i = 0; i < 4; i++) begin
      bus_read(ADDR_KEY_CHAR, SIZE_WORD, key_char_expect());  // Last one empty
    end
    bus_read(ADDR_KEY_STATUS, SIZE_WORD, status_expect());
    drain_reads();
    end_test("key_filtering", err_before);
  endtask

  task automatic queue_full_status();
    int err_before;
    err_before = errors;
    for (int i = 0; i < QUEUE_DEPTH + 3; i++) begin
      key_event(1'b1, key_code_t'(8'h60 + i));
    end
    bus_read(ADDR_KEY_STATUS, SIZE_WORD, status_expect());  // Full, not empty, drop
    bus_read(ADDR_KEY_STATUS, SIZE_WORD, status_expect());  // Drop now clear
    for (int i = 0; i < QUEUE_DEPTH + 1; i++) begin
      bus_read(ADDR_KEY_CHAR, SIZE_WORD, key_char_expect());
    end
    bus_read(ADDR_KEY_STATUS, SIZE_WORD, status_expect());
    drain_reads();
    end_test("queue_full_status", err_before);
  endtask

  task automatic video_and_unmapped();
    addr_t base;
    int    err_before;
    err_before = errors;
    bus_write(ADDR_VIDEO_MODE, SIZE_WORD, 32'h0000_0001);
    idle_cycle();
    check_mode(mode_model);
    bus_read(ADDR_VIDEO_MODE, SIZE_WORD, word_t'(mode_model));
    bus_write(ADDR_VIDEO_MODE, SIZE_WORD, 32'hffff_fffe);  // Bit 0 clear
    idle_cycle();
    check_mode(mode_model);
    bus_read(ADDR_VIDEO_MODE, SIZE_WORD, word_t'(mode_model));
    set_force(1'b1);
    check_mode(1'b1);
    bus_read(ADDR_VIDEO_MODE, SIZE_WORD, word_t'(mode_model));  // Register unforced
    drain_reads();
    set_force(1'b0);
    check_mode(mode_model);
    // Unmapped writes alias a RAM index in their low bits
    rng  = xorshift(rng);
    base = addr_t'({rng[RAM_INDEX_W-1:0], 2'b00});
    bus_write(base, SIZE_WORD, 32'hcafe_f00d);
    bus_write(base | 32'h0000_2000, SIZE_WORD, 32'hdead_beef);
    bus_write(32'h0001_000c, SIZE_WORD, 32'h0000_0001);
    bus_read(base, SIZE_WORD, ram_expect(base, SIZE_WORD));
    bus_read(base | 32'h0000_2000, SIZE_WORD, '0);
    bus_read(32'h0001_000c, SIZE_WORD, '0);
    bus_read(32'hffff_fffc, SIZE_WORD, '0);
    drain_reads();
    end_test("video_and_unmapped", err_before);
  endtask

  initial begin
    rst_n        <= 1'b0;
    bus_addr_i   <= '0;
    bus_we_i     <= 1'b0;
    bus_re_i     <= 1'b0;
    bus_size_i   <= SIZE_WORD;
    bus_wdata_i  <= '0;
    key_valid_i  <= 1'b0;
    key_make_i   <= 1'b0;
    key_code_i   <= '0;
    mode_force_i <= 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    drop_model   = 1'b0;
    mode_model   = 1'b0;
    rng          = 32'haef6;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    check_mode(1'b0);  // Mode clear out of reset
    word_read_write();
    lane_access();
    key_filtering();
    queue_full_status();
    video_and_unmapped();
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
